// File: Makefile
TOP = issue_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timing --top-module $(TOP) -f project.f -o sim_issue

run: build
	./obj_dir/sim_issue | tee sim.log
	grep -q "Result: PASSED" sim.log

lint:
	verilator --lint-only --assert --timing --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir sim.log

// File: hdl/core_isa_pkg.sv
package core_isa_pkg;

  typedef logic [31:0] word;
  typedef logic [4:0] reg_addr;

  // One bit per architectural register
  typedef logic [31:0] reg_mask;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_t;

  typedef enum logic [2:0] {
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU,
    BR_JAL,
    BR_JALR
  } branch_op_t;

  typedef enum logic [2:0] {
    MEM_LB,
    MEM_LH,
    MEM_LW,
    MEM_SB,
    MEM_SH,
    MEM_SW
  } mem_op_t;

  typedef enum logic [1:0] {
    CSR_RW,
    CSR_RS,
    CSR_RC
  } csr_op_t;

  // CSR view of the operand word
  typedef struct packed {
    logic [11:0] csr_addr;
    logic [4:0]  zimm;
    logic [14:0] pad;
  } csr_operand_t;

  typedef union packed {
    word          imm;
    csr_operand_t csr;
  } operand_u;

endpackage

// File: hdl/core_issue_pkg.sv
package core_issue_pkg;

  localparam int NUM_REGS = 32;
  localparam int SKID_DEPTH = 2;
  localparam int SKID_CNT_W = $clog2(SKID_DEPTH + 1);

  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_BRANCH,
    UNIT_CTRL_STATUS,
    UNIT_MEM
  } unit_sel_t;

  // Decoded instruction as it enters the issue stage
  typedef struct packed {
    unit_sel_t               unit_sel;
    core_isa_pkg::reg_addr   rs1;
    core_isa_pkg::reg_addr   rs2;
    core_isa_pkg::reg_addr   rd;
    logic                    rd_write;
    logic                    use_rs1;
    logic                    use_rs2;
    logic                    use_imm;
    core_isa_pkg::alu_op_t   alu_op;
    core_isa_pkg::branch_op_t branch_op;
    core_isa_pkg::mem_op_t   mem_op;
    core_isa_pkg::csr_op_t   csr_op;
    core_isa_pkg::word       pc;
    core_isa_pkg::operand_u  operand;
  } issue_data_t;

  typedef struct packed {
    core_isa_pkg::alu_op_t op;
    core_isa_pkg::word     src1;
    core_isa_pkg::word     src2;
    core_isa_pkg::reg_addr rd;
    logic                  rd_write;
  } alu_data_t;

  typedef struct packed {
    core_isa_pkg::branch_op_t op;
    core_isa_pkg::word        pc;
    core_isa_pkg::word        src1;
    core_isa_pkg::word        src2;
    core_isa_pkg::word        imm;
    core_isa_pkg::reg_addr    rd;
  } branch_data_t;

  typedef struct packed {
    core_isa_pkg::csr_op_t op;
    logic [11:0]           csr_addr;
    core_isa_pkg::word     src;
    core_isa_pkg::reg_addr rd;
  } ctrl_status_data_t;

  typedef struct packed {
    core_isa_pkg::mem_op_t op;
    core_isa_pkg::word     base;
    core_isa_pkg::word     offset;
    core_isa_pkg::word     store_data;
    core_isa_pkg::reg_addr rd;
  } mem_data_t;

endpackage

// File: hdl/issue_dispatch.sv
`timescale 1ns/10ps

module issue_dispatch (
  input  logic                               clk_core,
  input  logic                               rst_core_n,
  input  logic                               stall_i,
  input  logic                               flush_req_i,
  input  core_issue_pkg::issue_data_t        issue_data_i,
  input  logic                               valid_i,
  input  core_isa_pkg::reg_mask              pending_i,
  input  core_isa_pkg::word                  rs1_data_i,
  input  core_isa_pkg::word                  rs2_data_i,
  output logic                               hazard_o,
  output logic                               set_pending_o,
  output core_isa_pkg::reg_addr              set_rd_o,
  output core_issue_pkg::unit_sel_t          unit_sel_o,
  output logic                               alu_valid_o,
  output logic                               branch_valid_o,
  output logic                               ctrl_status_valid_o,
  output logic                               mem_valid_o,
  output core_issue_pkg::alu_data_t          alu_data_o,
  output core_issue_pkg::branch_data_t       branch_data_o,
  output core_issue_pkg::ctrl_status_data_t  ctrl_status_data_o,
  output core_issue_pkg::mem_data_t          mem_data_o
);

  logic rs1_busy;
  logic rs2_busy;
  logic advance;

  core_issue_pkg::alu_data_t         alu_d;
  core_issue_pkg::branch_data_t      branch_d;
  core_issue_pkg::ctrl_status_data_t ctrl_status_d;
  core_issue_pkg::mem_data_t         mem_d;
  core_issue_pkg::unit_sel_t         unit_q;

  // Only sources that the instruction actually reads count
  assign rs1_busy = issue_data_i.use_rs1 & pending_i[issue_data_i.rs1];
  assign rs2_busy = issue_data_i.use_rs2 & pending_i[issue_data_i.rs2];
  assign hazard_o = valid_i & (rs1_busy | rs2_busy);

  // A hazard leaves a bubble in the output register
  assign advance = valid_i & ~hazard_o & ~stall_i;

  // Mark the destination as soon as the instruction moves on
  assign set_pending_o = advance & issue_data_i.rd_write & (issue_data_i.rd != '0);
  assign set_rd_o      = issue_data_i.rd;

  always_comb begin
    alu_d.op       = issue_data_i.alu_op;
    // auipc style ops take the pc when rs1 is unused
    alu_d.src1     = issue_data_i.use_rs1 ? rs1_data_i : issue_data_i.pc;
    alu_d.src2     = issue_data_i.use_imm ? issue_data_i.operand.imm : rs2_data_i;
    alu_d.rd       = issue_data_i.rd;
    alu_d.rd_write = issue_data_i.rd_write;

    branch_d.op   = issue_data_i.branch_op;
    branch_d.pc   = issue_data_i.pc;
    branch_d.src1 = rs1_data_i;
    branch_d.src2 = rs2_data_i;
    branch_d.imm  = issue_data_i.operand.imm;
    branch_d.rd   = issue_data_i.rd;

    // CSR queue decodes the operand word as address plus zimm
    ctrl_status_d.op       = issue_data_i.csr_op;
    ctrl_status_d.csr_addr = issue_data_i.operand.csr.csr_addr;
    ctrl_status_d.src      = issue_data_i.use_imm ?
                             {27'b0, issue_data_i.operand.csr.zimm} : rs1_data_i;
    ctrl_status_d.rd       = issue_data_i.rd;

    mem_d.op         = issue_data_i.mem_op;
    mem_d.base       = rs1_data_i;
    mem_d.offset     = issue_data_i.operand.imm;
    mem_d.store_data = rs2_data_i;
    mem_d.rd         = issue_data_i.rd;
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      alu_valid_o         <= 1'b0;
      branch_valid_o      <= 1'b0;
      ctrl_status_valid_o <= 1'b0;
      mem_valid_o         <= 1'b0;
      unit_q              <= core_issue_pkg::UNIT_ALU;
    end else if (flush_req_i) begin
      alu_valid_o         <= 1'b0;
      branch_valid_o      <= 1'b0;
      ctrl_status_valid_o <= 1'b0;
      mem_valid_o         <= 1'b0;
    end else if (!stall_i) begin
      alu_valid_o         <= advance & (issue_data_i.unit_sel == core_issue_pkg::UNIT_ALU);
      branch_valid_o      <= advance & (issue_data_i.unit_sel == core_issue_pkg::UNIT_BRANCH);
      ctrl_status_valid_o <= advance &
                             (issue_data_i.unit_sel == core_issue_pkg::UNIT_CTRL_STATUS);
      mem_valid_o         <= advance & (issue_data_i.unit_sel == core_issue_pkg::UNIT_MEM);
      unit_q              <= issue_data_i.unit_sel;
    end
  end

  always_ff @(posedge clk_core) begin
    if (advance) begin
      alu_data_o         <= alu_d;
      branch_data_o      <= branch_d;
      ctrl_status_data_o <= ctrl_status_d;
      mem_data_o         <= mem_d;
    end
  end

  assign unit_sel_o = unit_q;

endmodule

// File: hdl/issue_regfile.sv
`timescale 1ns/10ps

module issue_regfile (
  input  logic                  clk_core,
  input  logic                  rst_core_n,
  input  core_isa_pkg::reg_addr rs1_addr_i,
  input  core_isa_pkg::reg_addr rs2_addr_i,
  input  logic                  wr_en_i,
  input  core_isa_pkg::reg_addr wr_addr_i,
  input  core_isa_pkg::word     wr_data_i,
  output core_isa_pkg::word     rs1_data_o,
  output core_isa_pkg::word     rs2_data_o
);

  core_isa_pkg::word regs_q [core_issue_pkg::NUM_REGS];

  // Architectural state starts at zero, x0 is never written
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      for (int i = 0; i < core_issue_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && (wr_addr_i != '0)) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Read sees only values from earlier edges
  always_comb begin
    rs1_data_o = regs_q[rs1_addr_i];
    rs2_data_o = regs_q[rs2_addr_i];
    if (rs1_addr_i == '0) begin
      rs1_data_o = '0;
    end
    if (rs2_addr_i == '0) begin
      rs2_data_o = '0;
    end
  end

endmodule

// File: hdl/issue_scoreboard.sv
`timescale 1ns/10ps

module issue_scoreboard (
  input  logic                       clk_core,
  input  logic                       rst_core_n,
  input  logic                       stall_i,
  input  logic                       flush_req_i,
  input  core_issue_pkg::issue_data_t issue_data_i,
  input  logic                       valid_i,
  input  logic                       set_pending_i,
  input  core_isa_pkg::reg_addr      set_rd_i,
  input  logic                       wr_en_i,
  input  core_isa_pkg::reg_addr      wr_addr_i,
  output core_issue_pkg::issue_data_t issue_data_o,
  output logic                       valid_o,
  output core_isa_pkg::reg_mask      pending_o,
  output core_isa_pkg::reg_addr      rs1_addr_o,
  output core_isa_pkg::reg_addr      rs2_addr_o
);

  core_issue_pkg::issue_data_t data_q;
  logic                        valid_q;
  core_isa_pkg::reg_mask       pending_q;
  core_isa_pkg::reg_mask       pending_d;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      valid_q <= 1'b0;
    end else if (flush_req_i) begin
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_core) begin
    if (!stall_i && valid_i) begin
      data_q <= issue_data_i;
    end
  end

  // New destination wins over a writeback to the same register
  always_comb begin
    pending_d = pending_q;
    if (wr_en_i) begin
      pending_d[wr_addr_i] = 1'b0;
    end
    if (set_pending_i) begin
      pending_d[set_rd_i] = 1'b1;
    end
    pending_d[0] = 1'b0;
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      pending_q <= '0;
    end else if (flush_req_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  assign issue_data_o = data_q;
  assign valid_o      = valid_q;
  assign pending_o    = pending_q;

  // Operands are read while the instruction sits here
  assign rs1_addr_o = data_q.rs1;
  assign rs2_addr_o = data_q.rs2;

endmodule

// File: hdl/issue_skid_buffer.sv
`timescale 1ns/10ps

module issue_skid_buffer #(
  parameter type data_t = logic
) (
  input  logic  clk_core,
  input  logic  rst_core_n,
  input  logic  flush_req_i,
  input  data_t data_i,
  input  logic  valid_i,
  output logic  ready_o,
  output data_t data_o,
  output logic  valid_o,
  input  logic  ready_i
);

  data_t slot_q [core_issue_pkg::SKID_DEPTH];

  logic [core_issue_pkg::SKID_CNT_W-1:0] count_q;
  logic [core_issue_pkg::SKID_CNT_W-1:0] count_after_pop;
  logic                                  push;
  logic                                  pop;

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  // Ready drops only once the spare slot is taken
  assign ready_o = (count_q != core_issue_pkg::SKID_CNT_W'(core_issue_pkg::SKID_DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = slot_q[0];

  assign count_after_pop = count_q - core_issue_pkg::SKID_CNT_W'(pop);

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      count_q <= '0;
    end else if (flush_req_i) begin
      count_q <= '0;
    end else begin
      count_q <= count_after_pop + core_issue_pkg::SKID_CNT_W'(push);
    end
  end

  // Head shifts forward on pop, new item lands in the first free slot
  always_ff @(posedge clk_core) begin
    if (pop) begin
      slot_q[0] <= slot_q[1];
    end
    if (push) begin
      if (count_after_pop == '0) begin
        slot_q[0] <= data_i;
      end else begin
        slot_q[1] <= data_i;
      end
    end
  end

endmodule

// File: hdl/issue_stage.sv
`timescale 1ns/10ps

module issue_stage (
  input  logic                              clk_core,
  input  logic                              rst_core_n,
  input  logic                              flush_req_i,
  output logic                              flush_ack_o,
  input  core_issue_pkg::issue_data_t       issue_data_i,
  input  logic                              valid_i,
  output logic                              ready_o,
  output core_issue_pkg::alu_data_t         alu_data_o,
  output logic                              alu_valid_o,
  input  logic                              alu_ready_i,
  output core_issue_pkg::branch_data_t      branch_data_o,
  output logic                              branch_valid_o,
  input  logic                              branch_ready_i,
  output core_issue_pkg::ctrl_status_data_t ctrl_status_data_o,
  output logic                              ctrl_status_valid_o,
  input  logic                              ctrl_status_ready_i,
  output core_issue_pkg::mem_data_t         mem_data_o,
  output logic                              mem_valid_o,
  input  logic                              mem_ready_i,
  input  logic                              wr_en_i,
  input  core_isa_pkg::reg_addr             wr_addr_i,
  input  core_isa_pkg::word                 wr_data_i
);

  core_isa_pkg::reg_addr rs1_addr;
  core_isa_pkg::reg_addr rs2_addr;
  core_isa_pkg::word     rs1_data;
  core_isa_pkg::word     rs2_data;

  core_issue_pkg::issue_data_t sb_data;
  logic                        sb_valid;
  core_isa_pkg::reg_mask       pending;

  logic                      hazard;
  logic                      set_pending;
  core_isa_pkg::reg_addr     set_rd;
  core_issue_pkg::unit_sel_t disp_unit;

  logic disp_alu_valid;
  logic disp_branch_valid;
  logic disp_ctrl_status_valid;
  logic disp_mem_valid;

  core_issue_pkg::alu_data_t         disp_alu_data;
  core_issue_pkg::branch_data_t      disp_branch_data;
  core_issue_pkg::ctrl_status_data_t disp_ctrl_status_data;
  core_issue_pkg::mem_data_t         disp_mem_data;

  logic alu_skid_ready;
  logic branch_skid_ready;
  logic ctrl_status_skid_ready;
  logic mem_skid_ready;
  logic sel_ready;
  logic disp_busy;
  logic disp_stall;
  logic stall;

  always_comb begin
    case (disp_unit)
      core_issue_pkg::UNIT_ALU:         sel_ready = alu_skid_ready;
      core_issue_pkg::UNIT_BRANCH:      sel_ready = branch_skid_ready;
      core_issue_pkg::UNIT_CTRL_STATUS: sel_ready = ctrl_status_skid_ready;
      default:                          sel_ready = mem_skid_ready;
    endcase
  end

  assign disp_busy = disp_alu_valid | disp_branch_valid |
                     disp_ctrl_status_valid | disp_mem_valid;

  // Dispatch output waits only on a full target queue
  assign disp_stall = disp_busy & ~sel_ready;

  // Scoreboard also holds on a source hazard
  assign stall   = hazard | disp_stall;
  assign ready_o = ~stall;

  issue_regfile regfile_i (
    .clk_core,
    .rst_core_n,
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .wr_en_i,
    .wr_addr_i,
    .wr_data_i,
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  issue_scoreboard scoreboard_i (
    .clk_core,
    .rst_core_n,
    .stall_i       (stall),
    .flush_req_i,
    .issue_data_i,
    .valid_i,
    .set_pending_i (set_pending),
    .set_rd_i      (set_rd),
    .wr_en_i,
    .wr_addr_i,
    .issue_data_o  (sb_data),
    .valid_o       (sb_valid),
    .pending_o     (pending),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr)
  );

  issue_dispatch dispatch_i (
    .clk_core,
    .rst_core_n,
    .stall_i             (disp_stall),
    .flush_req_i,
    .issue_data_i        (sb_data),
    .valid_i             (sb_valid),
    .pending_i           (pending),
    .rs1_data_i          (rs1_data),
    .rs2_data_i          (rs2_data),
    .hazard_o            (hazard),
    .set_pending_o       (set_pending),
    .set_rd_o            (set_rd),
    .unit_sel_o          (disp_unit),
    .alu_valid_o         (disp_alu_valid),
    .branch_valid_o      (disp_branch_valid),
    .ctrl_status_valid_o (disp_ctrl_status_valid),
    .mem_valid_o         (disp_mem_valid),
    .alu_data_o          (disp_alu_data),
    .branch_data_o       (disp_branch_data),
    .ctrl_status_data_o  (disp_ctrl_status_data),
    .mem_data_o          (disp_mem_data)
  );

  // Dispatch hands over only in cycles where it also advances
  issue_skid_buffer #(.data_t(core_issue_pkg::alu_data_t)) alu_skid_i (
    .clk_core, .rst_core_n, .flush_req_i,
    .data_i  (disp_alu_data),
    .valid_i (disp_alu_valid & ~disp_stall),
    .ready_o (alu_skid_ready),
    .data_o  (alu_data_o),
    .valid_o (alu_valid_o),
    .ready_i (alu_ready_i)
  );

  issue_skid_buffer #(.data_t(core_issue_pkg::branch_data_t)) branch_skid_i (
    .clk_core, .rst_core_n, .flush_req_i,
    .data_i  (disp_branch_data),
    .valid_i (disp_branch_valid & ~disp_stall),
    .ready_o (branch_skid_ready),
    .data_o  (branch_data_o),
    .valid_o (branch_valid_o),
    .ready_i (branch_ready_i)
  );

  issue_skid_buffer #(.data_t(core_issue_pkg::ctrl_status_data_t)) ctrl_status_skid_i (
    .clk_core, .rst_core_n, .flush_req_i,
    .data_i  (disp_ctrl_status_data),
    .valid_i (disp_ctrl_status_valid & ~disp_stall),
    .ready_o (ctrl_status_skid_ready),
    .data_o  (ctrl_status_data_o),
    .valid_o (ctrl_status_valid_o),
    .ready_i (ctrl_status_ready_i)
  );

  issue_skid_buffer #(.data_t(core_issue_pkg::mem_data_t)) mem_skid_i (
    .clk_core, .rst_core_n, .flush_req_i,
    .data_i  (disp_mem_data),
    .valid_i (disp_mem_valid & ~disp_stall),
    .ready_o (mem_skid_ready),
    .data_o  (mem_data_o),
    .valid_o (mem_valid_o),
    .ready_i (mem_ready_i)
  );

  // Ack follows each flush request by one cycle
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      flush_ack_o <= 1'b0;
    end else begin
      flush_ack_o <= flush_req_i;
    end
  end

endmodule

// File: project.f
hdl/core_isa_pkg.sv
hdl/core_issue_pkg.sv
hdl/issue_regfile.sv
hdl/issue_scoreboard.sv
hdl/issue_dispatch.sv
hdl/issue_skid_buffer.sv
hdl/issue_stage.sv
sim/issue_clkgen.sv
sim/issue_chk.sv
sim/issue_tb.sv

// File: sim/issue_chk.sv
`timescale 1ns/10ps

module issue_chk (
  input logic                              clk_core,
  input logic                              rst_core_n,
  input logic                              flush_req_i,
  input logic                              flush_ack_i,
  input logic                              ready_i,
  input logic                              hazard_i,
  input logic                              wr_en_i,
  input logic [3:0]                        disp_valid_i,
  input logic [3:0]                        out_valid_i,
  input logic [3:0]                        out_ready_i,
  input core_issue_pkg::alu_data_t         alu_data_i,
  input core_issue_pkg::branch_data_t      branch_data_i,
  input core_issue_pkg::ctrl_status_data_t ctrl_status_data_i,
  input core_issue_pkg::mem_data_t         mem_data_i
);

  // Bit order of the vectors is alu, branch, ctrl_status, mem from the top
  int unsigned fail_count = 0;

  a_reset_quiet: assert property (@(posedge clk_core)
    !rst_core_n |-> (out_valid_i == '0 && disp_valid_i == '0 && !flush_ack_i))
    else begin
      $error("Valid or flush ack high during reset");
      fail_count++;
    end

  a_flush_empty: assert property (@(posedge clk_core) disable iff (!rst_core_n)
    flush_req_i |=> (flush_ack_i && out_valid_i == '0 && disp_valid_i == '0))
    else begin
      $error("Flush not acknowledged or pipeline not empty after flush");
      fail_count++;
    end

  // A hazard clears only through a writeback
  a_hazard_waits: assert property (@(posedge clk_core) disable iff (!rst_core_n || flush_req_i)
    hazard_i && !wr_en_i |=> hazard_i)
    else begin
      $error("Hazard released without a writeback");
      fail_count++;
    end

  // Whatever dispatch hands over shows up on its own queue
  a_handover: assert property (@(posedge clk_core) disable iff (!rst_core_n || flush_req_i)
    disp_valid_i != '0 && ready_i |=> (out_valid_i & $past(disp_valid_i)) != '0)
    else begin
      $error("Dispatched instruction did not reach its queue");
      fail_count++;
    end

  a_alu_hold: assert property (@(posedge clk_core) disable iff (!rst_core_n || flush_req_i)
    out_valid_i[3] && !out_ready_i[3] |=> out_valid_i[3] && $stable(alu_data_i))
    else begin
      $error("ALU queue output dropped or changed while stalled");
      fail_count++;
    end

  a_branch_hold: assert property (@(posedge clk_core) disable iff (!rst_core_n || flush_req_i)
    out_valid_i[2] && !out_ready_i[2] |=> out_valid_i[2] && $stable(branch_data_i))
    else begin
      $error("Branch queue output dropped or changed while stalled");
      fail_count++;
    end

  a_cs_hold: assert property (@(posedge clk_core) disable iff (!rst_core_n || flush_req_i)
    out_valid_i[1] && !out_ready_i[1] |=> out_valid_i[1] && $stable(ctrl_status_data_i))
    else begin
      $error("Control-status queue output dropped or changed while stalled");
      fail_count++;
    end

  a_mem_hold: assert property (@(posedge clk_core) disable iff (!rst_core_n || flush_req_i)
    out_valid_i[0] && !out_ready_i[0] |=> out_valid_i[0] && $stable(mem_data_i))
    else begin
      $error("Memory queue output dropped or changed while stalled");
      fail_count++;
    end

endmodule

// File: sim/issue_clkgen.sv
`timescale 1ns/10ps

module issue_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: sim/issue_tb.sv
`timescale 1ns/10ps

module issue_tb;

  localparam int NUM_INSTR = 400;
  // About seven cycles per instruction in the worst case, plus drain time
  localparam int CYCLE_LIMIT = NUM_INSTR * 7 + 200;

  typedef struct packed {
    logic                  en;
    core_isa_pkg::reg_addr addr;
    core_isa_pkg::word     data;
  } wb_rec_t;

  typedef struct packed {
    logic [31:0]           due;
    core_isa_pkg::reg_addr addr;
    core_isa_pkg::word     data;
  } wb_slot_t;

  logic                              clk_core;
  logic                              rst_core_n;
  logic                              flush_req_i;
  logic                              flush_ack_o;
  core_issue_pkg::issue_data_t       issue_data_i;
  logic                              valid_i;
  logic                              ready_o;
  core_issue_pkg::alu_data_t         alu_data_o;
  logic                              alu_valid_o;
  logic                              alu_ready_i;
  core_issue_pkg::branch_data_t      branch_data_o;
  logic                              branch_valid_o;
  logic                              branch_ready_i;
  core_issue_pkg::ctrl_status_data_t ctrl_status_data_o;
  logic                              ctrl_status_valid_o;
  logic                              ctrl_status_ready_i;
  core_issue_pkg::mem_data_t         mem_data_o;
  logic                              mem_valid_o;
  logic                              mem_ready_i;
  logic                              wr_en_i;
  core_isa_pkg::reg_addr             wr_addr_i;
  core_isa_pkg::word                 wr_data_i;

  // Model state: spec follows issue order, committed follows writebacks
  core_isa_pkg::word spec_regs [32];
  core_isa_pkg::word committed_regs [32];
  core_isa_pkg::reg_mask inflight = '0;

  core_issue_pkg::alu_data_t         exp_alu [$];
  core_issue_pkg::branch_data_t      exp_branch [$];
  core_issue_pkg::ctrl_status_data_t exp_cs [$];
  core_issue_pkg::mem_data_t         exp_mem [$];
  wb_rec_t                           wb_info [4][$];
  wb_slot_t                          wb_sched [$];

  core_issue_pkg::issue_data_t cur_instr;
  bit          have_instr = 1'b0;
  logic [31:0] lcg_state = 32'd48;
  int          cycle = 0;
  int          issued = 0;
  int          errors = 0;
  int          flush_count = 0;

  issue_clkgen clkgen_i (
    .clk_o   (clk_core),
    .rst_n_o (rst_core_n)
  );

  issue_stage dut_i (.*);

  initial begin
    flush_req_i         = 1'b0;
    issue_data_i        = '0;
    valid_i             = 1'b0;
    alu_ready_i         = 1'b0;
    branch_ready_i      = 1'b0;
    ctrl_status_ready_i = 1'b0;
    mem_ready_i         = 1'b0;
    wr_en_i             = 1'b0;
    wr_addr_i           = '0;
    wr_data_i           = '0;
    for (int i = 0; i < 32; i++) begin
      spec_regs[i]      = '0;
      committed_regs[i] = '0;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Random instruction over x0..x7, sources marked used where the unit reads them
  function automatic core_issue_pkg::issue_data_t make_instr();
    core_issue_pkg::issue_data_t d;
    logic [31:0]                 r;
    r = next_rand();
    d = '0;
    d.unit_sel  = core_issue_pkg::unit_sel_t'(r[31:30]);
    d.rs1       = {2'b0, r[29:27]};
    d.rs2       = {2'b0, r[26:24]};
    d.rd        = {2'b0, r[23:21]};
    d.rd_write  = r[20];
    d.use_imm   = r[18];
    d.alu_op    = core_isa_pkg::alu_op_t'(r[17:14] % 4'd10);
    d.branch_op = core_isa_pkg::branch_op_t'(r[13:11]);
    d.mem_op    = core_isa_pkg::mem_op_t'(r[10:8] % 3'd6);
    d.csr_op    = core_isa_pkg::csr_op_t'(r[7:6] % 2'd3);
    d.pc        = {next_rand()};
    d.pc[1:0]   = 2'b00;
    d.operand.imm = next_rand();
    case (d.unit_sel)
      core_issue_pkg::UNIT_ALU: begin
        d.use_rs1 = r[5];
        d.use_rs2 = !d.use_imm;
      end
      core_issue_pkg::UNIT_CTRL_STATUS: begin
        d.use_rs1 = !d.use_imm;
        d.use_rs2 = 1'b0;
      end
      default: begin
        d.use_rs1 = 1'b1;
        d.use_rs2 = 1'b1;
      end
    endcase
    // No second writer to a register that still waits for its writeback
    if (inflight[d.rd]) begin
      d.rd_write = 1'b0;
    end
    return d;
  endfunction

  task automatic record_accept(input core_issue_pkg::issue_data_t d);
    core_isa_pkg::word                 v1;
    core_isa_pkg::word                 v2;
    wb_rec_t                           w;
    core_issue_pkg::alu_data_t         a;
    core_issue_pkg::branch_data_t      b;
    core_issue_pkg::ctrl_status_data_t c;
    core_issue_pkg::mem_data_t         m;
    v1 = spec_regs[d.rs1];
    v2 = spec_regs[d.rs2];
    w.en   = d.rd_write && (d.rd != '0);
    w.addr = d.rd;
    w.data = next_rand();
    if (w.en) begin
      spec_regs[d.rd] = w.data;
      inflight[d.rd]  = 1'b1;
    end
    case (d.unit_sel)
      core_issue_pkg::UNIT_ALU: begin
        a.op       = d.alu_op;
        a.src1     = d.use_rs1 ? v1 : d.pc;
        a.src2     = d.use_imm ? d.operand.imm : v2;
        a.rd       = d.rd;
        a.rd_write = d.rd_write;
        exp_alu.push_back(a);
      end
      core_issue_pkg::UNIT_BRANCH: begin
        b.op   = d.branch_op;
        b.pc   = d.pc;
        b.src1 = v1;
        b.src2 = v2;
        b.imm  = d.operand.imm;
        b.rd   = d.rd;
        exp_branch.push_back(b);
      end
      core_issue_pkg::UNIT_CTRL_STATUS: begin
        c.op       = d.csr_op;
        c.csr_addr = d.operand.csr.csr_addr;
        c.src      = d.use_imm ? {27'b0, d.operand.csr.zimm} : v1;
        c.rd       = d.rd;
        exp_cs.push_back(c);
      end
      default: begin
        m.op         = d.mem_op;
        m.base       = v1;
        m.offset     = d.operand.imm;
        m.store_data = v2;
        m.rd         = d.rd;
        exp_mem.push_back(m);
      end
    endcase
    wb_info[int'(d.unit_sel)].push_back(w);
  endtask

  task automatic compare(input string name, input logic [159:0] exp, input logic [159:0] got);
    assert (exp === got) else begin
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic note_unexpected(input string name);
    $display("Instruction left the %s queue at %0t with none expected", name, $time);
    errors++;
  endtask

  // Schedule the writeback of a finished instruction 2 to 6 cycles out
  task automatic retire(input int u);
    wb_rec_t     w;
    wb_slot_t    s;
    logic [31:0] r;
    w = wb_info[u].pop_front();
    r = next_rand();
    if (w.en) begin
      s.due  = cycle + 2 + int'(r[31:29] % 3'd5);
      s.addr = w.addr;
      s.data = w.data;
      wb_sched.push_back(s);
    end
  endtask

  task automatic check_outputs();
    if (alu_valid_o && alu_ready_i) begin
      assert (exp_alu.size() > 0) else note_unexpected("alu");
      if (exp_alu.size() > 0) begin
        compare("alu_data_o", 160'(exp_alu.pop_front()), 160'(alu_data_o));
        retire(0);
      end
    end
    if (branch_valid_o && branch_ready_i) begin
      assert (exp_branch.size() > 0) else note_unexpected("branch");
      if (exp_branch.size() > 0) begin
        compare("branch_data_o", 160'(exp_branch.pop_front()), 160'(branch_data_o));
        retire(1);
      end
    end
    if (ctrl_status_valid_o && ctrl_status_ready_i) begin
      assert (exp_cs.size() > 0) else note_unexpected("control-status");
      if (exp_cs.size() > 0) begin
        compare("ctrl_status_data_o", 160'(exp_cs.pop_front()), 160'(ctrl_status_data_o));
        retire(2);
      end
    end
    if (mem_valid_o && mem_ready_i) begin
      assert (exp_mem.size() > 0) else note_unexpected("memory");
      if (exp_mem.size() > 0) begin
        compare("mem_data_o", 160'(exp_mem.pop_front()), 160'(mem_data_o));
        retire(3);
      end
    end
  endtask

  task automatic drive_writeback(output bit now);
    wb_slot_t s;
    int       idx;
    now = 1'b0;
    idx = 0;
    wr_en_i <= 1'b0;
    foreach (wb_sched[i]) begin
      if (!now && wb_sched[i].due <= cycle) begin
        idx = i;
        now = 1'b1;
      end
    end
    if (now) begin
      s = wb_sched[idx];
      wb_sched.delete(idx);
      wr_en_i   <= 1'b1;
      wr_addr_i <= s.addr;
      wr_data_i <= s.data;
      committed_regs[s.addr] = s.data;
      inflight[s.addr]       = 1'b0;
    end
  endtask

  // Everything not yet handed to a unit is dropped
  task automatic flush_model();
    exp_alu.delete();
    exp_branch.delete();
    exp_cs.delete();
    exp_mem.delete();
    for (int u = 0; u < 4; u++) begin
      wb_info[u].delete();
    end
    spec_regs = committed_regs;
    inflight  = '0;
  endtask

  function automatic bit queues_empty();
    return exp_alu.size() == 0 && exp_branch.size() == 0 &&
           exp_cs.size() == 0 && exp_mem.size() == 0;
  endfunction

  task automatic end_run(input bit timed_out);
    if (timed_out) begin
      $display("Timeout after %0d cycles with instructions still in flight", cycle);
    end
    $display("Errors: %0d testbench, %0d assertion", errors, dut_i.chk_i.fail_count);
    if (!timed_out && errors == 0 && dut_i.chk_i.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  always @(posedge clk_core) begin
    logic [31:0] r;
    bit          wb_now;
    bit          flushing;
    if (rst_core_n) begin
      if (cycle >= CYCLE_LIMIT) begin
        end_run(1'b1);
      end else if (issued >= NUM_INSTR && !have_instr && queues_empty() &&
                   wb_sched.size() == 0 && !wr_en_i) begin
        end_run(1'b0);
      end else begin
        cycle++;
        check_outputs();
        if (flush_req_i) begin
          flush_model();
        end else if (valid_i && ready_o) begin
          record_accept(cur_instr);
          issued++;
          have_instr = 1'b0;
        end
        if (!have_instr && issued < NUM_INSTR) begin
          cur_instr  = make_instr();
          have_instr = 1'b1;
        end
        drive_writeback(wb_now);
        r = next_rand();
        // Flush only once no writeback is owed, with all queues held
        flushing = (wb_sched.size() == 0) && !wb_now &&
                   (r[31:26] == 6'd0 || (issued >= NUM_INSTR / 2 && flush_count == 0));
        if (flushing) begin
          flush_count++;
        end
        flush_req_i         <= flushing;
        valid_i             <= have_instr && !flushing;
        issue_data_i        <= cur_instr;
        alu_ready_i         <= !flushing && r[25:24] != 2'd0;
        branch_ready_i      <= !flushing && r[23:22] != 2'd0;
        ctrl_status_ready_i <= !flushing && r[21:20] != 2'd0;
        mem_ready_i         <= !flushing && r[19:18] != 2'd0;
      end
    end
  end

endmodule

bind issue_stage issue_chk chk_i (
  .clk_core,
  .rst_core_n,
  .flush_req_i,
  .flush_ack_i        (flush_ack_o),
  .ready_i            (ready_o),
  .hazard_i           (hazard),
  .wr_en_i,
  .disp_valid_i       ({disp_alu_valid, disp_branch_valid, disp_ctrl_status_valid,
                        disp_mem_valid}),
  .out_valid_i        ({alu_valid_o, branch_valid_o, ctrl_status_valid_o, mem_valid_o}),
  .out_ready_i        ({alu_ready_i, branch_ready_i, ctrl_status_ready_i, mem_ready_i}),
  .alu_data_i         (alu_data_o),
  .branch_data_i      (branch_data_o),
  .ctrl_status_data_i (ctrl_status_data_o),
  .mem_data_i         (mem_data_o)
);
